// File: rtl/core_pkg.sv
//####################
// shared widths, encodings and structs of the rv32i subset core
// word accesses only, no trap or csr support
// addr bit REGBUS_SEL_BIT set selects the register bus
//####################
`default_nettype none

package core_pkg;

  localparam int XLEN           = 32;
  localparam int REG_AW         = 5;
  localparam int IRAM_AW        = 8;
  localparam int DRAM_AW        = 8;
  localparam int REGBUS_SEL_BIT = 31;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_IMM    = 7'b0010011,
    OPC_REG    = 7'b0110011,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_EXEC,
    ST_MEM,
    ST_HALT
  } seq_state_t;

  typedef struct packed {
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [XLEN-1:0]   imm;
    alu_op_t           alu_op;
    logic              use_imm;
    logic              reg_we;
    logic              is_load;
    logic              is_store;
    logic              is_branch;
    logic              br_ne;
    logic              illegal;
  } dec_t;

  typedef struct packed {
    logic            we;
    logic            re;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } mem_req_t;

  // same layout as mem_req_t, this one leaves the core
  typedef struct packed {
    logic            we;
    logic            re;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } reg_bus_t;

endpackage

`default_nettype wire

// File: rtl/iram.sv
//####################
// instruction RAM, 2**IRAM_AW words
// write address is a byte address, low two bits ignored
// read data arrives one cycle after the address
//####################
`timescale 1ns/10ps
`default_nettype none

module iram import core_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            i_we,
  input  logic [XLEN-1:0] i_waddr,
  input  logic [XLEN-1:0] i_wdata,
  input  logic [XLEN-1:0] i_raddr,
  output logic [XLEN-1:0] o_rdata
);

  logic [XLEN-1:0] mem [2**IRAM_AW];

  always_ff @(posedge clk) begin
    if (i_we)
      mem[i_waddr[IRAM_AW+1:2]] <= i_wdata;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_rdata <= '0;
    end else begin
      o_rdata <= mem[i_raddr[IRAM_AW+1:2]];
    end
  end

endmodule

`default_nettype wire

// File: rtl/decoder.sv
//####################
// instruction decode for the supported subset
// anything outside LUI, OP-IMM, OP, BEQ/BNE, LW, SW sets illegal
//####################
`timescale 1ns/10ps
`default_nettype none

module decoder import core_pkg::*; (
  input  logic [XLEN-1:0] i_inst,
  output dec_t            o_dec
);

  opcode_t         opc;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;

  assign opc    = opcode_t'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'b0};

  always_comb begin
    o_dec     = '0;
    o_dec.rd  = i_inst[11:7];
    o_dec.rs1 = i_inst[19:15];
    o_dec.rs2 = i_inst[24:20];
    case (opc)
      OPC_LUI: begin
        o_dec.imm     = imm_u;
        o_dec.alu_op  = ALU_PASS_B;
        o_dec.use_imm = 1'b1;
        o_dec.reg_we  = 1'b1;
      end
      OPC_IMM: begin
        o_dec.imm     = imm_i;
        o_dec.use_imm = 1'b1;
        o_dec.reg_we  = 1'b1;
        case (funct3)
          3'b000:  o_dec.alu_op = ALU_ADD;
          3'b010:  o_dec.alu_op = ALU_SLT;
          3'b100:  o_dec.alu_op = ALU_XOR;
          3'b110:  o_dec.alu_op = ALU_OR;
          3'b111:  o_dec.alu_op = ALU_AND;
          default: o_dec.illegal = 1'b1;
        endcase
      end
      OPC_REG: begin
        o_dec.reg_we = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: o_dec.alu_op = ALU_ADD;
          {7'h20, 3'b000}: o_dec.alu_op = ALU_SUB;
          {7'h00, 3'b010}: o_dec.alu_op = ALU_SLT;
          {7'h00, 3'b100}: o_dec.alu_op = ALU_XOR;
          {7'h00, 3'b110}: o_dec.alu_op = ALU_OR;
          {7'h00, 3'b111}: o_dec.alu_op = ALU_AND;
          default:         o_dec.illegal = 1'b1;
        endcase
      end
      OPC_BRANCH: begin
        // beq is funct3 000, bne is 001
        o_dec.imm       = imm_b;
        o_dec.is_branch = 1'b1;
        o_dec.br_ne     = funct3[0];
        o_dec.illegal   = (funct3[2:1] != 2'b00);
      end
      OPC_LOAD: begin
        o_dec.imm     = imm_i;
        o_dec.use_imm = 1'b1;
        o_dec.reg_we  = 1'b1;
        o_dec.is_load = 1'b1;
        o_dec.illegal = (funct3 != 3'b010);
      end
      OPC_STORE: begin
        o_dec.imm      = imm_s;
        o_dec.use_imm  = 1'b1;
        o_dec.is_store = 1'b1;
        o_dec.illegal  = (funct3 != 3'b010);
      end
      default: o_dec.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/regfile.sv
//####################
// 32 x 32 register file, x0 reads zero
// reads are combinational, write on clk edge
//####################
`timescale 1ns/10ps
`default_nettype none

module regfile import core_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [REG_AW-1:0] i_rs1,
  input  logic [REG_AW-1:0] i_rs2,
  input  logic [REG_AW-1:0] i_rd,
  input  logic              i_we,
  input  logic [XLEN-1:0]   i_wdata,
  output logic [XLEN-1:0]   o_rs1_data,
  output logic [XLEN-1:0]   o_rs2_data
);

  // no storage behind x0
  logic [XLEN-1:0] regs [1:2**REG_AW-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 2**REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd != '0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// File: rtl/alu.sv
//####################
// combinational alu, slt is signed
// o_equal compares the raw operands for beq/bne
//####################
`timescale 1ns/10ps
`default_nettype none

module alu import core_pkg::*; (
  input  alu_op_t         i_op,
  input  logic [XLEN-1:0] i_a,
  input  logic [XLEN-1:0] i_b,
  output logic [XLEN-1:0] o_result,
  output logic            o_equal
);

  logic lt;

  assign lt = $signed(i_a) < $signed(i_b);

  always_comb begin
    case (i_op)
      ALU_ADD:    o_result = i_a + i_b;
      ALU_SUB:    o_result = i_a - i_b;
      ALU_SLT:    o_result = {{(XLEN-1){1'b0}}, lt};
      ALU_XOR:    o_result = i_a ^ i_b;
      ALU_OR:     o_result = i_a | i_b;
      ALU_AND:    o_result = i_a & i_b;
      // lui just forwards the upper immediate
      ALU_PASS_B: o_result = i_b;
      default:    o_result = '0;
    endcase
  end

  assign o_equal = (i_a == i_b);

endmodule

`default_nettype wire

// File: rtl/lsu.sv
//####################
// data RAM plus register bus split on addr bit REGBUS_SEL_BIT
// word accesses only, low two address bits ignored
// register bus has no ready, read data expected the cycle after re
//####################
`timescale 1ns/10ps
`default_nettype none

module lsu import core_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  mem_req_t        i_req,
  output logic [XLEN-1:0] o_rdata,
  output reg_bus_t        o_reg_bus,
  input  logic [XLEN-1:0] i_reg_bus_rdat
);

  logic [XLEN-1:0]    dram [2**DRAM_AW];
  logic [XLEN-1:0]    dram_q;
  logic [DRAM_AW-1:0] widx;
  logic               sel_bus;
  logic               dram_we;
  logic               dram_re;
  logic               rd_bus_q;

  assign sel_bus = i_req.addr[REGBUS_SEL_BIT];
  assign widx    = i_req.addr[DRAM_AW+1:2];
  assign dram_we = i_req.we & ~sel_bus;
  assign dram_re = i_req.re & ~sel_bus;

  always_ff @(posedge clk) begin
    if (dram_we)
      dram[widx] <= i_req.wdata;
    if (dram_re)
      dram_q <= dram[widx];
  end

  // remember where the last read went
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_bus_q <= 1'b0;
    end else if (i_req.re) begin
      rd_bus_q <= sel_bus;
    end
  end

  always_comb begin
    o_reg_bus = '0;
    if (sel_bus && (i_req.we || i_req.re)) begin
      o_reg_bus.we    = i_req.we;
      o_reg_bus.re    = i_req.re;
      o_reg_bus.addr  = i_req.addr;
      o_reg_bus.wdata = i_req.wdata;
    end
  end

  assign o_rdata = rd_bus_q ? i_reg_bus_rdat : dram_q;

endmodule

`default_nettype wire

// File: rtl/core_seq.sv
//####################
// sequencer and pc, one instruction in flight
// 2 cycles per instruction, 3 for loads
// i_run only sampled in idle, illegal opcode halts until reset
//####################
`timescale 1ns/10ps
`default_nettype none

module core_seq import core_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_run,
  input  dec_t              i_dec,
  input  logic [XLEN-1:0]   i_alu_result,
  input  logic              i_alu_equal,
  input  logic [XLEN-1:0]   i_rs2_data,
  input  logic [XLEN-1:0]   i_load_data,
  output logic [XLEN-1:0]   o_pc,
  output logic [REG_AW-1:0] o_rd,
  output logic              o_rd_we,
  output logic [XLEN-1:0]   o_rd_wdata,
  output mem_req_t          o_req,
  output logic [XLEN-1:0]   o_alu_b,
  output logic              o_halted
);

  seq_state_t        state_q;
  logic [XLEN-1:0]   pc_q;
  logic [REG_AW-1:0] load_rd_q;
  logic              exec_ok;
  logic              in_mem;
  logic              br_taken;

  assign exec_ok  = (state_q == ST_EXEC) & ~i_dec.illegal;
  assign in_mem   = (state_q == ST_MEM);
  assign br_taken = i_dec.is_branch & (i_alu_equal ^ i_dec.br_ne);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      pc_q    <= '0;
    end else begin
      case (state_q)
        ST_IDLE:  state_q <= i_run ? ST_FETCH : ST_IDLE;
        ST_FETCH: state_q <= ST_EXEC;
        ST_EXEC: begin
          if (i_dec.illegal) begin
            state_q <= ST_HALT;
          end else begin
            state_q <= i_dec.is_load ? ST_MEM : ST_FETCH;
            pc_q    <= br_taken ? pc_q + i_dec.imm : pc_q + 32'd4;
          end
        end
        ST_MEM:   state_q <= ST_FETCH;
        default:  state_q <= ST_HALT;
      endcase
    end
  end

  // load destination kept for the write in ST_MEM
  always_ff @(posedge clk) begin
    if (exec_ok && i_dec.is_load)
      load_rd_q <= i_dec.rd;
  end

  assign o_alu_b    = i_dec.use_imm ? i_dec.imm : i_rs2_data;
  assign o_rd       = in_mem ? load_rd_q : i_dec.rd;
  assign o_rd_we    = in_mem | (exec_ok & i_dec.reg_we & ~i_dec.is_load);
  assign o_rd_wdata = in_mem ? i_load_data : i_alu_result;

  assign o_req.we    = exec_ok & i_dec.is_store;
  assign o_req.re    = exec_ok & i_dec.is_load;
  assign o_req.addr  = i_alu_result;
  assign o_req.wdata = i_rs2_data;

  assign o_pc     = pc_q;
  assign o_halted = (state_q == ST_HALT);

endmodule

`default_nettype wire

// File: rtl/rv_core.sv
//####################
// rv32i subset core top, instances only
// load the iram while i_run is low, then raise i_run
//####################
`timescale 1ns/10ps
`default_nettype none

module rv_core import core_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            i_run,
  input  logic            i_iram_we,
  input  logic [XLEN-1:0] i_iram_waddr,
  input  logic [XLEN-1:0] i_iram_wdata,
  output reg_bus_t        o_reg_bus,
  input  logic [XLEN-1:0] i_reg_bus_rdat,
  output logic            o_halted
);

  logic [XLEN-1:0]   pc;
  logic [XLEN-1:0]   inst;
  dec_t              dec;
  logic [XLEN-1:0]   rs1_data;
  logic [XLEN-1:0]   rs2_data;
  logic [XLEN-1:0]   alu_b;
  logic [XLEN-1:0]   alu_result;
  logic              alu_equal;
  logic [REG_AW-1:0] rd;
  logic              rd_we;
  logic [XLEN-1:0]   rd_wdata;
  mem_req_t          req;
  logic [XLEN-1:0]   load_data;

  iram u_iram (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_we    (i_iram_we),
    .i_waddr (i_iram_waddr),
    .i_wdata (i_iram_wdata),
    .i_raddr (pc),
    .o_rdata (inst)
  );

  decoder u_decoder (
    .i_inst (inst),
    .o_dec  (dec)
  );

  regfile u_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_rs1      (dec.rs1),
    .i_rs2      (dec.rs2),
    .i_rd       (rd),
    .i_we       (rd_we),
    .i_wdata    (rd_wdata),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  alu u_alu (
    .i_op     (dec.alu_op),
    .i_a      (rs1_data),
    .i_b      (alu_b),
    .o_result (alu_result),
    .o_equal  (alu_equal)
  );

  lsu u_lsu (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_req          (req),
    .o_rdata        (load_data),
    .o_reg_bus      (o_reg_bus),
    .i_reg_bus_rdat (i_reg_bus_rdat)
  );

  core_seq u_core_seq (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_run        (i_run),
    .i_dec        (dec),
    .i_alu_result (alu_result),
    .i_alu_equal  (alu_equal),
    .i_rs2_data   (rs2_data),
    .i_load_data  (load_data),
    .o_pc         (pc),
    .o_rd         (rd),
    .o_rd_we      (rd_we),
    .o_rd_wdata   (rd_wdata),
    .o_req        (req),
    .o_alu_b      (alu_b),
    .o_halted     (o_halted)
  );

endmodule

`default_nettype wire

// File: tests/tb_core.sv
//####################
// self-checking testbench for rv_core
// every test resets the core, loads a program and runs it until the
// illegal opcode at its end halts the core
// register bus model answers each re with lfsr data in the next cycle
//####################
`timescale 1ns/10ps
`default_nettype none

module tb_core import core_pkg::*; ();

  localparam logic [6:0]  OPCODE_IMM  = 7'b0010011;
  localparam logic [6:0]  OPCODE_LOAD = 7'b0000011;
  localparam logic [31:0] BUS_BASE    = 32'h8000_0000;
  localparam logic [31:0] HALT_INST   = 32'hffff_ffff;
  // executed instructions per test with the branch loop at its longest (6 turns)
  localparam int EXEC_INSTR  = 34 + 8 + 5 + (8 + 4 * 6) + 4;
  localparam int CYCLE_LIMIT = 3 * EXEC_INSTR + 200;

  logic        clk;
  logic        rst_n;
  logic        run;
  logic        iram_we;
  logic [31:0] iram_waddr;
  logic [31:0] iram_wdata;
  reg_bus_t    reg_bus;
  logic [31:0] bus_rdat;
  logic        halted;

  logic [31:0] lfsr_state = 32'hb9f141b7;
  int          errors = 0;
  int          mark = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          run_cycles = 0;
  int          slot = 0;
  logic        running = 1'b0;
  string       cur_test;

  logic [31:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_rd_addr [$];
  logic [31:0] wr_addr_q [$];
  logic [31:0] wr_data_q [$];
  logic [31:0] rd_addr_q [$];
  logic [31:0] rdat_log [$];

  // add, sub, slt, xor, or, and
  int f3_tab [6] = '{0, 0, 2, 4, 6, 7};
  int f7_tab [6] = '{0, 32, 0, 0, 0, 0};

  rv_core u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_run          (run),
    .i_iram_we      (iram_we),
    .i_iram_waddr   (iram_waddr),
    .i_iram_wdata   (iram_wdata),
    .o_reg_bus      (reg_bus),
    .i_reg_bus_rdat (bus_rdat),
    .o_halted       (halted)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    if (running) begin
      run_cycles <= run_cycles + 1;
      if (run_cycles >= CYCLE_LIMIT) begin
        $display("timeout: core did not halt within %0d run cycles", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
      end
    end
  end

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // register bus model
  always @(posedge clk) begin
    assert (reg_bus.we || reg_bus.re || reg_bus == '0) else begin
      errors++;
      $display("[ERROR] %s: register bus without strobe expected %h actual %h",
               cur_test, 66'h0, reg_bus);
    end
    assert (!(reg_bus.we || reg_bus.re) || reg_bus.addr[31]) else begin
      errors++;
      $display("register bus strobe for an address outside the bus region");
    end
    if (reg_bus.we) begin
      wr_addr_q.push_back(reg_bus.addr);
      wr_data_q.push_back(reg_bus.wdata);
    end
    if (reg_bus.re) begin
      rd_addr_q.push_back(reg_bus.addr);
      rdat_log.push_back(take_bits(32));
      bus_rdat <= rdat_log[rdat_log.size() - 1];
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) halted |-> !(reg_bus.we || reg_bus.re))
    else begin
      errors++;
      $display("register bus strobe after the core halted");
    end

  function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                         input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [31:0] imm, input int rs1, input int f3,
                                         input int rd, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] addi(input int rd, input int rs1, input logic [31:0] imm);
    return i_type(imm, rs1, 0, rd, OPCODE_IMM);
  endfunction

  function automatic logic [31:0] load_word(input int rd, input int rs1, input int off);
    return i_type(off, rs1, 2, rd, OPCODE_LOAD);
  endfunction

  function automatic logic [31:0] store_word(input int rs2, input int rs1, input int off);
    return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch(input int rs2, input int rs1, input int f3,
                                         input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] lui(input int rd, input logic [31:0] imm);
    return {imm[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic logic [31:0] expect_alu(input int kind, input logic [31:0] a,
                                             input logic [31:0] b);
    case (kind)
      0:       return a + b;
      1:       return a - b;
      2:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3:       return a ^ b;
      4:       return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic expect_write(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // lower 12 bits are sign extended by addi, so round the upper part
  task automatic load_const(input int rd, input logic [31:0] value);
    logic [31:0] hi;
    hi = (value + 32'h800) >> 12;
    emit(lui(rd, hi));
    emit(addi(rd, rd, value));
  endtask

  task automatic store_and_expect(input int rs, input logic [31:0] value);
    emit(store_word(rs, 10, slot * 4));
    expect_write(BUS_BASE + slot * 4, value);
    slot++;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    mark = errors;
    slot = 0;
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    exp_rd_addr.delete();
    wr_addr_q.delete();
    wr_data_q.delete();
    rd_addr_q.delete();
    rdat_log.delete();
    apply_reset();
  endtask

  task automatic run_program();
    for (int i = 0; i < prog.size(); i++) begin
      @(posedge clk);
      iram_we    <= 1'b1;
      iram_waddr <= i * 4;
      iram_wdata <= prog[i];
    end
    @(posedge clk);
    iram_we <= 1'b0;
    run     <= 1'b1;
    @(posedge clk);
    run     <= 1'b0;
    running <= 1'b1;
    @(posedge clk);
    while (!halted) @(posedge clk);
    running <= 1'b0;
  endtask

  task automatic compare_bus();
    assert (wr_addr_q.size() == exp_addr.size()) else begin
      errors++;
      $display("[ERROR] %s: write count expected %0d actual %0d",
               cur_test, exp_addr.size(), wr_addr_q.size());
    end
    for (int i = 0; i < exp_addr.size() && i < wr_addr_q.size(); i++) begin
      assert (wr_addr_q[i] == exp_addr[i]) else begin
        errors++;
        $display("[ERROR] %s: write %0d addr expected %h actual %h",
                 cur_test, i, exp_addr[i], wr_addr_q[i]);
      end
      assert (wr_data_q[i] == exp_data[i]) else begin
        errors++;
        $display("[ERROR] %s: write %0d data expected %h actual %h",
                 cur_test, i, exp_data[i], wr_data_q[i]);
      end
    end
    assert (rd_addr_q.size() == exp_rd_addr.size()) else begin
      errors++;
      $display("[ERROR] %s: read count expected %0d actual %0d",
               cur_test, exp_rd_addr.size(), rd_addr_q.size());
    end
    for (int i = 0; i < exp_rd_addr.size() && i < rd_addr_q.size(); i++) begin
      assert (rd_addr_q[i] == exp_rd_addr[i]) else begin
        errors++;
        $display("[ERROR] %s: read %0d addr expected %h actual %h",
                 cur_test, i, exp_rd_addr[i], rd_addr_q[i]);
      end
    end
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors != mark) begin
      tests_failed++;
      $display("[%s] failed", cur_test);
    end else begin
      $display("[%s] passed", cur_test);
    end
  endtask

  task automatic idle_after_reset();
    begin_test("idle");
    repeat (10) begin
      @(posedge clk);
      assert (reg_bus == '0) else begin
        errors++;
        $display("[ERROR] %s: bus expected %h actual %h", cur_test, 66'h0, reg_bus);
      end
      assert (!halted) else begin
        errors++;
        $display("[ERROR] %s: halted expected 0 actual 1", cur_test);
      end
    end
    finish_test();
  endtask

  task automatic arith_ops();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] u;
    begin_test("arith");
    a = take_bits(32);
    b = take_bits(32);
    emit(lui(10, BUS_BASE >> 12));
    load_const(1, a);
    store_and_expect(1, a);
    load_const(2, b);
    store_and_expect(2, b);
    for (int k = 0; k < 6; k++) begin
      emit(r_type(f7_tab[k], 2, 1, f3_tab[k], 3));
      store_and_expect(3, expect_alu(k, a, b));
    end
    // swapped operands so slt also sees the opposite order
    emit(r_type(0, 1, 2, 2, 3));
    store_and_expect(3, expect_alu(2, b, a));
    for (int k = 0; k < 6; k++) begin
      if (k != 1) begin
        imm = take_bits(12);
        emit(i_type(imm, 1, f3_tab[k], 4, OPCODE_IMM));
        store_and_expect(4, expect_alu(k, a, {{20{imm[11]}}, imm[11:0]}));
      end
    end
    u = take_bits(20);
    emit(lui(5, u));
    store_and_expect(5, u << 12);
    emit(HALT_INST);
    run_program();
    compare_bus();
    finish_test();
  endtask

  task automatic dram_round_trip();
    logic [31:0] v;
    logic [31:0] addr;
    begin_test("dram");
    v = take_bits(32);
    addr = take_bits(8) << 2;
    emit(lui(10, BUS_BASE >> 12));
    load_const(1, v);
    emit(addi(5, 0, addr));
    emit(store_word(1, 5, 0));
    emit(load_word(6, 5, 0));
    store_and_expect(6, v);
    emit(HALT_INST);
    run_program();
    compare_bus();
    finish_test();
  endtask

  task automatic bus_load_increment();
    begin_test("bus_load");
    emit(lui(10, BUS_BASE >> 12));
    emit(load_word(7, 10, 16));
    emit(addi(7, 7, 1));
    emit(store_word(7, 10, 16));
    emit(HALT_INST);
    exp_rd_addr.push_back(BUS_BASE + 16);
    run_program();
    if (rdat_log.size() == 1)
      expect_write(BUS_BASE + 16, rdat_log[0] + 1);
    compare_bus();
    finish_test();
  endtask

  task automatic branch_countdown();
    int n;
    begin_test("branch");
    n = 3 + int'(take_bits(2));
    emit(lui(10, BUS_BASE >> 12));
    emit(addi(1, 0, n));
    // store the counter, advance the pointer, count down
    emit(store_word(1, 10, 0));
    emit(addi(10, 10, 4));
    emit(addi(1, 1, -1));
    emit(branch(0, 1, 1, -12));
    // taken beq skips the marker
    emit(branch(0, 1, 0, 8));
    emit(addi(1, 0, 99));
    emit(store_word(1, 10, 0));
    // x10 is never zero here
    emit(branch(0, 10, 0, 8));
    emit(addi(1, 1, 5));
    emit(store_word(1, 10, 4));
    emit(HALT_INST);
    for (int i = 0; i < n; i++)
      expect_write(BUS_BASE + 4 * i, n - i);
    expect_write(BUS_BASE + 4 * n, 0);
    expect_write(BUS_BASE + 4 * n + 4, 5);
    run_program();
    compare_bus();
    finish_test();
  endtask

  task automatic x0_then_halt();
    begin_test("halt");
    emit(lui(10, BUS_BASE >> 12));
    emit(addi(0, 0, 123));
    emit(store_word(0, 10, 0));
    emit(HALT_INST);
    emit(store_word(0, 10, 4));
    expect_write(BUS_BASE, 0);
    run_program();
    repeat (10) begin
      @(posedge clk);
      assert (halted) else begin
        errors++;
        $display("core left the halted state without a reset");
      end
    end
    compare_bus();
    finish_test();
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    run        = 1'b0;
    iram_we    = 1'b0;
    iram_waddr = '0;
    iram_wdata = '0;
    bus_rdat   = '0;
    idle_after_reset();
    arith_ops();
    dram_round_trip();
    bus_load_increment();
    branch_countdown();
    x0_then_halt();
    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
rtl/core_pkg.sv
rtl/iram.sv
rtl/decoder.sv
rtl/regfile.sv
rtl/alu.sv
rtl/lsu.sv
rtl/core_seq.sv
rtl/rv_core.sv
tests/tb_core.sv
